// ==== verilog/eq_pkg.sv ====
/* blur equivalence harness, shared types */
`default_nettype none

package eq_pkg;

    localparam int img_width      = 8;
    localparam int img_height     = 8;
    localparam int frame_pixels   = img_width * img_height;
    localparam int interior_count = (img_width - 2) * (img_height - 2);
    localparam int pix_index_w    = $clog2(frame_pixels);

    typedef logic [2:0]             coord_t;
    typedef logic [7:0]             pixel_t;
    typedef logic [pix_index_w-1:0] pix_index_t;   // flat raster index

    // 3x3 neighbourhood, top-left first
    typedef struct packed {
        pixel_t tl;
        pixel_t tc;
        pixel_t tr;
        pixel_t ml;
        pixel_t mc;
        pixel_t mr;
        pixel_t bl;
        pixel_t bc;
        pixel_t br;
        coord_t row;   // center position
        coord_t col;
    } window_t;

    typedef struct packed {
        pixel_t value;
        coord_t row;
        coord_t col;
    } blur_result_t;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_check,
        st_finish
    } eq_state_e;

endpackage

`default_nettype wire

// ==== verilog/line_buffer.sv ====
/* line buffer and 3x3 window */
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
    input  logic            clk,
    input  logic            rst_init,
    input  logic            pix_accept,
    input  eq_pkg::pixel_t  pix_data,
    output logic            win_strobe,
    output eq_pkg::window_t win
);

    import eq_pkg::*;

    coord_t col_pos;
    coord_t row_pos;
    logic   interior;

    pixel_t row_mem0 [img_width];   // one row back
    pixel_t row_mem1 [img_width];   // two rows back

    // index 2 is the oldest row, 0 the incoming pixel
    pixel_t [2:0] col_new;
    pixel_t [2:0] col_d1;
    pixel_t [2:0] col_d2;

    assign col_new  = {row_mem1[col_pos], row_mem0[col_pos], pix_data};
    assign interior = (row_pos >= 3'd2) && (col_pos >= 3'd2);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            col_pos    <= '0;
            row_pos    <= '0;
            win_strobe <= 1'b0;
        end else begin
            win_strobe <= pix_accept && interior;
            if (pix_accept) begin
                if (col_pos == coord_t'(img_width - 1)) begin
                    col_pos <= '0;
                    if (row_pos == coord_t'(img_height - 1))
                        row_pos <= '0;   // frame end
                    else
                        row_pos <= row_pos + 3'd1;
                end else begin
                    col_pos <= col_pos + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_accept) begin
            row_mem1[col_pos] <= row_mem0[col_pos];
            row_mem0[col_pos] <= pix_data;
            col_d2 <= col_d1;
            col_d1 <= col_new;

            win.tl  <= col_d2[2];
            win.tc  <= col_d1[2];
            win.tr  <= col_new[2];
            win.ml  <= col_d2[1];
            win.mc  <= col_d1[1];
            win.mr  <= col_new[1];
            win.bl  <= col_d2[0];
            win.bc  <= col_d1[0];
            win.br  <= col_new[0];
            win.row <= row_pos - 3'd1;   // center lags by one row and column
            win.col <= col_pos - 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gauss_kernel.sv ====
/* pipelined gaussian kernel */
`timescale 1ns/100ps
`default_nettype none

module gauss_kernel (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 win_strobe,
    input  eq_pkg::window_t      win,
    output logic                 impl_strobe,
    output eq_pkg::blur_result_t impl_result
);

    import eq_pkg::*;

    logic [9:0]  top_sum;
    logic [9:0]  mid_sum;
    logic [9:0]  bot_sum;
    logic [11:0] total;

    logic        s1_valid;
    logic [9:0]  s1_top;
    logic [10:0] s1_mid;
    logic [9:0]  s1_bot;
    coord_t      s1_row;
    coord_t      s1_col;

    // 1-2-1 along each row
    assign top_sum = {2'b0, win.tl} + {1'b0, win.tc, 1'b0} + {2'b0, win.tr};
    assign mid_sum = {2'b0, win.ml} + {1'b0, win.mc, 1'b0} + {2'b0, win.mr};
    assign bot_sum = {2'b0, win.bl} + {1'b0, win.bc, 1'b0} + {2'b0, win.br};

    assign total = {2'b0, s1_top} + {1'b0, s1_mid} + {2'b0, s1_bot};

    always_ff @(posedge clk) begin
        if (rst_init) begin
            s1_valid    <= 1'b0;
            impl_strobe <= 1'b0;
        end else begin
            s1_valid    <= win_strobe;
            impl_strobe <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_top <= top_sum;
        s1_mid <= {mid_sum, 1'b0};   // middle row weighs double
        s1_bot <= bot_sum;
        s1_row <= win.row;
        s1_col <= win.col;

        impl_result.value <= total[11:4];   // divide by 16
        impl_result.row   <= s1_row;
        impl_result.col   <= s1_col;
    end

endmodule

`default_nettype wire

// ==== verilog/blur_ref.sv ====
/* frame-stepped blur reference */
`timescale 1ns/100ps
`default_nettype none

module blur_ref (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 pix_accept,
    input  eq_pkg::pixel_t       pix_data,
    output logic                 ref_strobe,
    output eq_pkg::blur_result_t ref_result,
    output logic                 ref_done
);

    import eq_pkg::*;

    pixel_t frame_mem [frame_pixels];

    pix_index_t wr_idx;
    pix_index_t step_cnt;
    logic       stepping;
    coord_t     step_row;
    coord_t     step_col;

    coord_t      row_up;
    coord_t      row_dn;
    coord_t      col_lt;
    coord_t      col_rt;
    logic [9:0]  corner_sum;
    logic [9:0]  edge_sum;
    logic [11:0] total;

    function automatic pix_index_t addr(coord_t r, coord_t c);
        return pix_index_t'(r * img_width + c);
    endfunction

    assign row_up = step_row - 3'd1;
    assign row_dn = step_row + 3'd1;
    assign col_lt = step_col - 3'd1;
    assign col_rt = step_col + 3'd1;

    // weights 1 at the corners, 2 on the edges, 4 in the middle
    assign corner_sum = 10'(frame_mem[addr(row_up, col_lt)]) + 10'(frame_mem[addr(row_up, col_rt)])
                      + 10'(frame_mem[addr(row_dn, col_lt)]) + 10'(frame_mem[addr(row_dn, col_rt)]);
    assign edge_sum   = 10'(frame_mem[addr(row_up, step_col)]) + 10'(frame_mem[addr(step_row, col_lt)])
                      + 10'(frame_mem[addr(step_row, col_rt)]) + 10'(frame_mem[addr(row_dn, step_col)]);
    assign total = {2'b0, corner_sum} + {1'b0, edge_sum, 1'b0}
                 + {2'b0, frame_mem[addr(step_row, step_col)], 2'b0};

    assign ref_strobe       = stepping;
    assign ref_done         = stepping && (step_cnt == pix_index_t'(interior_count - 1));
    assign ref_result.value = total[11:4];
    assign ref_result.row   = step_row;
    assign ref_result.col   = step_col;

    always_ff @(posedge clk) begin
        if (rst_init) begin
            wr_idx   <= '0;
            stepping <= 1'b0;
            step_cnt <= '0;
            step_row <= 3'd1;
            step_col <= 3'd1;
        end else begin
            if (pix_accept)
                wr_idx <= wr_idx + 1'b1;   // wraps at frame end

            if (pix_accept && wr_idx == pix_index_t'(frame_pixels - 1)) begin
                stepping <= 1'b1;
                step_cnt <= '0;
                step_row <= 3'd1;
                step_col <= 3'd1;
            end else if (stepping) begin
                step_cnt <= step_cnt + 1'b1;
                if (ref_done)
                    stepping <= 1'b0;
                if (step_col == coord_t'(img_width - 2)) begin
                    step_col <= 3'd1;
                    step_row <= step_row + 3'd1;
                end else begin
                    step_col <= step_col + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_accept)
            frame_mem[wr_idx] <= pix_data;
    end

endmodule

`default_nettype wire

// ==== verilog/result_fifo.sv ====
/* streaming result FIFO */
`timescale 1ns/100ps
`default_nettype none

module result_fifo (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 push,
    input  eq_pkg::blur_result_t push_data,
    input  logic                 pop,
    output eq_pkg::blur_result_t head,
    output logic                 empty
);

    import eq_pkg::*;

    blur_result_t fifo_mem [frame_pixels];

    // extra msb tells full from empty
    logic [pix_index_w:0] wr_ptr;
    logic [pix_index_w:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign head  = fifo_mem[rd_ptr[pix_index_w-1:0]];

    always_ff @(posedge clk) begin
        if (rst_init) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;   // pop on empty is ignored
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr[pix_index_w-1:0]] <= push_data;
    end

endmodule

`default_nettype wire

// ==== verilog/eq_control.sv ====
/* equivalence control FSM */
`timescale 1ns/100ps
`default_nettype none

module eq_control (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 pixel_strobe,
    input  eq_pkg::pixel_t       pixel_in,
    output logic                 pix_accept,
    output eq_pkg::pixel_t       pix_data,
    input  logic                 ref_strobe,
    input  eq_pkg::blur_result_t ref_result,
    input  logic                 ref_done,
    input  eq_pkg::blur_result_t fifo_head,
    input  logic                 fifo_empty,
    output logic                 fifo_pop,
    output logic                 cmp_strobe,
    output eq_pkg::blur_result_t cmp_result,
    output logic                 mismatch,
    output logic                 frame_done,
    output logic                 busy
);

    import eq_pkg::*;

    eq_state_e  state;
    pix_index_t pix_cnt;

    // pixels arriving while busy are dropped here
    assign pix_accept = pixel_strobe && (state == st_idle || state == st_load);
    assign pix_data   = pixel_in;
    assign busy       = (state == st_check) || (state == st_finish);
    assign fifo_pop   = ref_strobe && (state == st_check);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            state      <= st_idle;
            pix_cnt    <= '0;
            cmp_strobe <= 1'b0;
            mismatch   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            cmp_strobe <= fifo_pop;
            mismatch   <= fifo_pop && (fifo_empty || fifo_head != ref_result);
            frame_done <= 1'b0;

            case (state)
                st_idle: begin
                    if (pix_accept) begin
                        pix_cnt <= pix_index_t'(1);
                        state   <= st_load;
                    end
                end
                st_load: begin
                    if (pix_accept) begin
                        if (pix_cnt == pix_index_t'(frame_pixels - 1)) begin
                            pix_cnt <= '0;
                            state   <= st_check;   // frame complete
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end
                end
                st_check: begin
                    if (ref_done)
                        state <= st_finish;
                end
                st_finish: begin
                    frame_done <= 1'b1;
                    state      <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop)
            cmp_result <= ref_result;   // report the reference value
    end

endmodule

`default_nettype wire

// ==== verilog/blur_eq_top.sv ====
/* blur equivalence harness top */
`timescale 1ns/100ps
`default_nettype none

module blur_eq_top (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 pixel_strobe,
    input  eq_pkg::pixel_t       pixel_in,
    output logic                 cmp_strobe,
    output eq_pkg::blur_result_t cmp_result,
    output logic                 mismatch,
    output logic                 frame_done,
    output logic                 busy
);

    import eq_pkg::*;

    logic         pix_accept;
    pixel_t       pix_data;
    logic         win_strobe;
    window_t      win;
    logic         impl_strobe;
    blur_result_t impl_result;
    logic         ref_strobe;
    blur_result_t ref_result;
    logic         ref_done;
    blur_result_t fifo_head;
    logic         fifo_empty;
    logic         fifo_pop;

    eq_control u_control (
        .clk          (clk),
        .rst_init     (rst_init),
        .pixel_strobe (pixel_strobe),
        .pixel_in     (pixel_in),
        .pix_accept   (pix_accept),
        .pix_data     (pix_data),
        .ref_strobe   (ref_strobe),
        .ref_result   (ref_result),
        .ref_done     (ref_done),
        .fifo_head    (fifo_head),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .cmp_strobe   (cmp_strobe),
        .cmp_result   (cmp_result),
        .mismatch     (mismatch),
        .frame_done   (frame_done),
        .busy         (busy)
    );

    // streaming implementation
    line_buffer u_line_buffer (
        .clk        (clk),
        .rst_init   (rst_init),
        .pix_accept (pix_accept),
        .pix_data   (pix_data),
        .win_strobe (win_strobe),
        .win        (win)
    );

    gauss_kernel u_kernel (
        .clk         (clk),
        .rst_init    (rst_init),
        .win_strobe  (win_strobe),
        .win         (win),
        .impl_strobe (impl_strobe),
        .impl_result (impl_result)
    );

    result_fifo u_fifo (
        .clk       (clk),
        .rst_init  (rst_init),
        .push      (impl_strobe),
        .push_data (impl_result),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty)
    );

    // frame-stepped reference
    blur_ref u_ref (
        .clk        (clk),
        .rst_init   (rst_init),
        .pix_accept (pix_accept),
        .pix_data   (pix_data),
        .ref_strobe (ref_strobe),
        .ref_result (ref_result),
        .ref_done   (ref_done)
    );

endmodule

`default_nettype wire

// ==== tb/eq_checker.sv ====
/* blur harness checker */
`timescale 1ns/100ps
`default_nettype none

module eq_checker (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 pixel_strobe,
    input  eq_pkg::pixel_t       pixel_in,
    input  logic                 cmp_strobe,
    input  eq_pkg::blur_result_t cmp_result,
    input  logic                 mismatch,
    input  logic                 frame_done,
    input  logic                 busy,
    output int                   check_count,
    output int                   error_count,
    output int                   cmp_count,
    output int                   done_count,
    output int                   drop_count
);

    import eq_pkg::*;

    // cycles counted from the last pixel of a frame
    localparam int cmp_first  = 2;
    localparam int cmp_last   = cmp_first + interior_count - 1;
    localparam int done_phase = cmp_last + 1;

    pixel_t       model_frame [frame_pixels];
    blur_result_t expected_q [$];
    int           load_cnt;
    int           phase;    // 0 while loading

    function automatic pixel_t blur_at(input int r, input int c);
        int sum;
        int w;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
                sum += w * int'(model_frame[(r + dr) * img_width + c + dc]);
            end
        end
        return pixel_t'(sum / 16);
    endfunction

    task automatic build_expected();
        blur_result_t res;
        expected_q.delete();
        for (int r = 1; r <= img_height - 2; r++) begin
            for (int c = 1; c <= img_width - 2; c++) begin
                res.value = blur_at(r, c);
                res.row   = coord_t'(r);
                res.col   = coord_t'(c);
                expected_q.push_back(res);
            end
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] t=%0t %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_result();
        blur_result_t exp;
        check_count++;
        if (expected_q.size() == 0) begin
            error_count++;
            $display("comparison reported at %0t with no expected result left", $time);
        end else begin
            exp = expected_q.pop_front();
            if (cmp_result !== exp) begin
                error_count++;
                $display("[FAIL] t=%0t result (%0d,%0d)=%0d, expected (%0d,%0d)=%0d",
                         $time, cmp_result.row, cmp_result.col, cmp_result.value,
                         exp.row, exp.col, exp.value);
            end
        end
    endtask

    // inputs change on the falling edge, so everything is stable here
    always @(posedge clk) begin
        logic exp_busy;
        logic exp_cmp;
        logic exp_done;
        if (rst_init) begin
            load_cnt    = 0;
            phase       = 0;
            check_count = 0;
            error_count = 0;
            cmp_count   = 0;
            done_count  = 0;
            drop_count  = 0;
            expected_q.delete();
        end else begin
            exp_busy = (phase >= 1) && (phase <= cmp_last);
            exp_cmp  = (phase >= cmp_first) && (phase <= cmp_last);
            exp_done = (phase == done_phase);

            check_bit("busy", busy, exp_busy);
            check_bit("cmp_strobe", cmp_strobe, exp_cmp);
            check_bit("frame_done", frame_done, exp_done);
            check_bit("mismatch", mismatch, 1'b0);

            if (cmp_strobe)
                compare_result();
            if (cmp_strobe)
                cmp_count++;
            if (frame_done)
                done_count++;

            if (pixel_strobe && exp_busy) begin
                drop_count++;   // harness ignores it too
            end else if (pixel_strobe) begin
                model_frame[load_cnt] = pixel_in;
                load_cnt++;
            end

            if (phase == done_phase)
                phase = 0;
            else if (phase > 0)
                phase++;

            if (load_cnt == frame_pixels) begin
                build_expected();
                load_cnt = 0;
                phase    = 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
/* blur harness testbench */
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    import eq_pkg::*;

    localparam int frame_runs    = 6;
    localparam int frame_timeout = 2000;   // cycles per frame
    localparam int idle_cycles   = 8;

    logic         clk;
    logic         rst_init;
    logic         pixel_strobe;
    pixel_t       pixel_in;
    logic         cmp_strobe;
    blur_result_t cmp_result;
    logic         mismatch;
    logic         frame_done;
    logic         busy;

    int          check_count;
    int          error_count;
    int          cmp_count;
    int          done_count;
    int          drop_count;
    int          tb_errors;
    logic        timed_out;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always #5 clk = ~clk;

    blur_eq_top dut_i (
        .clk          (clk),
        .rst_init     (rst_init),
        .pixel_strobe (pixel_strobe),
        .pixel_in     (pixel_in),
        .cmp_strobe   (cmp_strobe),
        .cmp_result   (cmp_result),
        .mismatch     (mismatch),
        .frame_done   (frame_done),
        .busy         (busy)
    );

    eq_checker chk_i (
        .clk          (clk),
        .rst_init     (rst_init),
        .pixel_strobe (pixel_strobe),
        .pixel_in     (pixel_in),
        .cmp_strobe   (cmp_strobe),
        .cmp_result   (cmp_result),
        .mismatch     (mismatch),
        .frame_done   (frame_done),
        .busy         (busy),
        .check_count  (check_count),
        .error_count  (error_count),
        .cmp_count    (cmp_count),
        .done_count   (done_count),
        .drop_count   (drop_count)
    );

    task automatic drive_random_pixel();
        rng          = xorshift32(rng);
        pixel_strobe = (rng[9:8] != 2'b00);   // roughly one gap in four
        rng          = xorshift32(rng);
        pixel_in     = rng[7:0];
    endtask

    // keeps strobing, also through busy, until the frame reports done
    task automatic run_frame(input int frame_idx);
        int start_done;
        int cycles;
        start_done = done_count;
        cycles     = 0;
        while (done_count == start_done && cycles < frame_timeout) begin
            @(negedge clk);
            drive_random_pixel();
            cycles++;
        end
        if (done_count == start_done) begin
            $display("timeout: frame %0d not done after %0d cycles", frame_idx, frame_timeout);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_init     = 1'b1;
        pixel_strobe = 1'b0;
        pixel_in     = '0;
        rng          = 32'd38;
        tb_errors    = 0;
        timed_out    = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_init = 1'b0;
        repeat (idle_cycles) @(negedge clk);   // outputs must stay quiet

        for (int f = 0; f < frame_runs; f++) begin
            if (!timed_out)
                run_frame(f);
        end
        @(negedge clk);
        pixel_strobe = 1'b0;
        repeat (4) @(negedge clk);

        if (!timed_out && cmp_count != frame_runs * interior_count) begin
            tb_errors++;
            $display("[FAIL] t=%0t %0d comparisons, expected %0d",
                     $time, cmp_count, frame_runs * interior_count);
        end
        if (!timed_out && done_count != frame_runs) begin
            tb_errors++;
            $display("[FAIL] t=%0t %0d frames done, expected %0d", $time, done_count, frame_runs);
        end
        if (drop_count == 0) begin
            tb_errors++;
            $display("no pixel was ever strobed while the harness was busy");
        end

        $display("checks=%0d errors=%0d compares=%0d frames=%0d dropped=%0d",
                 check_count, error_count + tb_errors, cmp_count, done_count, drop_count);
        if (error_count == 0 && tb_errors == 0 && !timed_out)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/eq_pkg.sv
verilog/line_buffer.sv
verilog/gauss_kernel.sv
verilog/blur_ref.sv
verilog/result_fifo.sv
verilog/eq_control.sv
verilog/blur_eq_top.sv
tb/eq_checker.sv
tb/tb_top.sv

// ==== Makefile ====
# Verilator build for the blur equivalence harness

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= PASS: all tests

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
